// ==== include/isa_fields.svh ====
`ifndef ISA_FIELDS_SVH
`define ISA_FIELDS_SVH

// Bit ranges of a 16-bit instruction word
`define ISA_OPCODE 15:12
`define ISA_RS     11:10
`define ISA_RT     9:8
`define ISA_RD     7:6
`define ISA_FUNCT  5:0

// Immediate, extended according to the opcode
`define ISA_IMM    7:0

// Jump target, joined with the upper four address bits
`define ISA_TARGET 11:0

`endif

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    // Data and address word
    typedef logic [15:0] word_t;

    // Four architectural registers
    typedef logic [1:0] reg_idx_t;

    // Instruction classes in bits 15:12
    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcode_e;

    // Register-type functions in bits 5:0
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_JRL = 6'd26,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR
    } alu_op_e;

    // BNE r0, r0, 0 is never taken and writes nothing
    localparam word_t nop_word = 16'h0000;

endpackage

// ==== logic/inst_queue.sv ====
`timescale 1ns/1ps

interface inst_stream_if
    import cpu_pkg::*;
();

    logic  valid;
    logic  ready;
    word_t inst;
    word_t pc;

    modport producer (output valid, output inst, output pc, input ready);
    modport consumer (input valid, input inst, input pc, output ready);

endinterface

module inst_queue
    import cpu_pkg::*;
#(
    parameter int QUEUE_DEPTH = 2
) (
    input logic clk,
    input logic reset_n,
    input logic flush,
    inst_stream_if.consumer in,
    inst_stream_if.producer out
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    word_t inst_mem [QUEUE_DEPTH];
    word_t pc_mem   [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign in.ready  = count != (PTR_W + 1)'(QUEUE_DEPTH);
    assign out.valid = count != '0;
    assign out.inst  = out.valid ? inst_mem[rd_ptr] : nop_word;
    assign out.pc    = pc_mem[rd_ptr];

    // Anything arriving during a flush is wrong-path
    assign push = in.valid && in.ready && !flush;
    assign pop  = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[wr_ptr] <= in.inst;
            pc_mem[wr_ptr]   <= in.pc;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  word_t data1,
    output logic  read_m1,
    output word_t address1,
    inst_stream_if.producer out
);

    word_t pc;
    logic  active;
    logic  offering;

    // Starts fetching the cycle after reset releases
    assign offering = active && out.ready;

    assign read_m1  = offering;
    assign address1 = pc;

    assign out.valid = offering;
    assign out.inst  = data1;
    assign out.pc    = pc;

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc     <= '0;
            active <= 1'b0;
        end else begin
            active <= 1'b1;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (out.valid && out.ready) begin
                // Always predict the next sequential word
                pc <= pc + 16'd1;
            end
        end
    end

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t read_idx1,
    input  reg_idx_t read_idx2,
    input  reg_idx_t write_idx,
    input  logic     write_en,
    input  word_t    write_data,
    output word_t    read_out1,
    output word_t    read_out2
);

    word_t regs [4];

    // Combinational reads
    assign read_out1 = regs[read_idx1];
    assign read_out2 = regs[read_idx2];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_idx] <= write_data;
        end
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu
    import cpu_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result
);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_NOT: begin
                result = ~a;
            end
            ALU_TCP: begin
                result = ~a + 16'd1;
            end
            ALU_SHL: begin
                result = {a[14:0], 1'b0};
            end
            ALU_SHR: begin
                // Arithmetic shift keeps the sign bit
                result = {a[15], a[15:1]};
            end
            default: begin
                result = a;
            end
        endcase
    end

endmodule

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ps
`include "isa_fields.svh"

module execute_unit
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  word_t read_data2,
    inst_stream_if.consumer in,
    output logic  redirect,
    output word_t redirect_pc,
    output logic  read_m2,
    output logic  write_m2,
    output word_t address2,
    output word_t write_data2,
    output word_t num_inst,
    output word_t output_port,
    output logic  is_halted
);

    localparam reg_idx_t link_reg = 2'd2;

    logic     fire;
    word_t    inst;
    opcode_e  op;
    funct_e   fn;
    word_t    imm_sext;
    word_t    imm_zext;
    word_t    pc_plus1;
    word_t    branch_target;
    word_t    jump_target;
    word_t    rs_val;
    word_t    rt_val;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    alu_op_e  alu_op;
    reg_idx_t write_idx;
    logic     write_en;
    word_t    write_data;
    logic     mem_to_reg;
    logic     link;
    logic     wwd;
    logic     halt;

    // Stop popping once halted so the queue backs up into fetch
    assign in.ready = !is_halted;
    assign fire     = in.valid && in.ready;

    // Idle cycles decode as a harmless nop
    assign inst = fire ? in.inst : nop_word;
    assign op   = opcode_e'(inst[`ISA_OPCODE]);
    assign fn   = funct_e'(inst[`ISA_FUNCT]);

    assign imm_sext      = 16'($signed(inst[`ISA_IMM]));
    assign imm_zext      = {8'h00, inst[`ISA_IMM]};
    assign pc_plus1      = in.pc + 16'd1;
    assign branch_target = pc_plus1 + imm_sext;
    assign jump_target   = {in.pc[15:12], inst[`ISA_TARGET]};

    register_file i_register_file (
        .clk        (clk),
        .reset_n    (reset_n),
        .read_idx1  (inst[`ISA_RS]),
        .read_idx2  (inst[`ISA_RT]),
        .write_idx  (write_idx),
        .write_en   (write_en),
        .write_data (write_data),
        .read_out1  (rs_val),
        .read_out2  (rt_val)
    );

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    //////////////////////////////////////////////////
    // Decode and branch resolution
    //////////////////////////////////////////////////

    always_comb begin
        alu_op      = ALU_ADD;
        alu_a       = rs_val;
        alu_b       = rt_val;
        write_idx   = inst[`ISA_RT];
        write_en    = 1'b0;
        mem_to_reg  = 1'b0;
        link        = 1'b0;
        read_m2     = 1'b0;
        write_m2    = 1'b0;
        redirect    = 1'b0;
        redirect_pc = branch_target;
        wwd         = 1'b0;
        halt        = 1'b0;
        case (op)
            OP_BNE: redirect = rs_val != rt_val;
            OP_BEQ: redirect = rs_val == rt_val;
            OP_BGZ: redirect = $signed(rs_val) > 0;
            OP_BLZ: redirect = $signed(rs_val) < 0;
            OP_ADI: begin
                alu_b    = imm_sext;
                write_en = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                alu_b    = imm_zext;
                write_en = 1'b1;
            end
            OP_LHI: begin
                alu_op   = ALU_OR;
                alu_a    = '0;
                alu_b    = {inst[`ISA_IMM], 8'h00};
                write_en = 1'b1;
            end
            OP_LWD: begin
                alu_b      = imm_sext;
                write_en   = 1'b1;
                mem_to_reg = 1'b1;
                read_m2    = 1'b1;
            end
            OP_SWD: begin
                alu_b    = imm_sext;
                write_m2 = 1'b1;
            end
            OP_JMP: begin
                redirect    = 1'b1;
                redirect_pc = jump_target;
            end
            OP_JAL: begin
                redirect    = 1'b1;
                redirect_pc = jump_target;
                link        = 1'b1;
                write_en    = 1'b1;
                write_idx   = link_reg;
            end
            OP_RTYPE: begin
                write_idx = inst[`ISA_RD];
                case (fn)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR,
                    FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                        // Low three funct bits line up with the ALU encoding
                        alu_op   = alu_op_e'(inst[2:0]);
                        write_en = 1'b1;
                    end
                    FN_WWD: wwd = 1'b1;
                    FN_JPR: begin
                        redirect    = 1'b1;
                        redirect_pc = rs_val;
                    end
                    FN_JRL: begin
                        redirect    = 1'b1;
                        redirect_pc = rs_val;
                        link        = 1'b1;
                        write_en    = 1'b1;
                        write_idx   = link_reg;
                    end
                    FN_HLT: halt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign address2    = alu_result;
    assign write_data2 = rt_val;
    assign write_data  = link ? pc_plus1 : (mem_to_reg ? read_data2 : alu_result);

    //////////////////////////////////////////////////
    // Retirement
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst    <= '0;
            output_port <= '0;
            is_halted   <= 1'b0;
        end else begin
            if (fire) begin
                num_inst <= num_inst + 16'd1;
            end
            if (wwd) begin
                output_port <= rs_val;
            end
            if (halt) begin
                is_halted <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/cpu.sv ====
`timescale 1ns/1ps

module cpu
    import cpu_pkg::*;
#(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic  clk,
    input  logic  reset_n,
    output logic  read_m1,
    output word_t address1,
    input  word_t data1,
    output logic  read_m2,
    output logic  write_m2,
    output word_t address2,
    input  word_t read_data2,
    output word_t write_data2,
    output word_t num_inst,
    output word_t output_port,
    output logic  is_halted
);

    logic  redirect;
    word_t redirect_pc;

    inst_stream_if fetch_to_queue ();
    inst_stream_if queue_to_exec ();

    fetch_unit i_fetch_unit (
        .clk         (clk),
        .reset_n     (reset_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .data1       (data1),
        .read_m1     (read_m1),
        .address1    (address1),
        .out         (fetch_to_queue.producer)
    );

    // Taken branches flush whatever was fetched behind them
    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_inst_queue (
        .clk     (clk),
        .reset_n (reset_n),
        .flush   (redirect),
        .in      (fetch_to_queue.consumer),
        .out     (queue_to_exec.producer)
    );

    execute_unit i_execute_unit (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_data2  (read_data2),
        .in          (queue_to_exec.consumer),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .read_m2     (read_m2),
        .write_m2    (write_m2),
        .address2    (address2),
        .write_data2 (write_data2),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

endmodule

// ==== bench/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker
    import cpu_pkg::*;
(
    input logic  clk,
    input logic  reset_n,
    input logic  read_m1,
    input logic  read_m2,
    input logic  write_m2,
    input word_t address1,
    input word_t num_inst,
    input logic  is_halted
);

    // Read by the testbench
    int fail_count = 0;

    data_port_exclusive: assert property (@(posedge clk) disable iff (reset_n)
        !(read_m2 && write_m2))
    else begin
        $error("read_m2 and write_m2 are high in the same cycle");
        fail_count++;
    end

    halt_sticky: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> is_halted)
    else begin
        $error("is_halted fell without a reset");
        fail_count++;
    end

    count_frozen: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> $stable(num_inst))
    else begin
        $error("num_inst changed while halted");
        fail_count++;
    end

    // Two cycles after halt a two-entry queue is full
    fetch_parked: assert property (@(posedge clk) disable iff (reset_n)
        is_halted && $past(is_halted, 2) |-> !read_m1 && $stable(address1))
    else begin
        $error("fetch still running while halted with a full queue");
        fail_count++;
    end

endmodule

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps
`include "isa_fields.svh"

module cpu_tb
    import cpu_pkg::*;
();

    typedef struct packed {
        word_t value;
        word_t count;
    } row_t;

    localparam word_t alu_a = 16'hA55A;
    localparam word_t alu_b = 16'h00F5;

    logic  clk;
    logic  reset_n;
    word_t data1;
    word_t read_data2;
    logic  read_m1;
    logic  read_m2;
    logic  write_m2;
    word_t address1;
    word_t address2;
    word_t write_data2;
    word_t num_inst;
    word_t output_port;
    logic  is_halted;

    word_t mem [256];
    row_t  expect_rows [$];
    word_t asm_pc = '0;
    word_t path_len = '0;
    logic  program_ready = 1'b0;
    int    seed = 10619;

    cpu #(
        .QUEUE_DEPTH (2)
    ) i_cpu (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .read_m2     (read_m2),
        .write_m2    (write_m2),
        .address2    (address2),
        .read_data2  (read_data2),
        .write_data2 (write_data2),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    bind cpu cpu_checker i_cpu_checker (
        .clk       (clk),
        .reset_n   (reset_n),
        .read_m1   (read_m1),
        .read_m2   (read_m2),
        .write_m2  (write_m2),
        .address1  (address1),
        .num_inst  (num_inst),
        .is_halted (is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Memory model shared by both ports
    //////////////////////////////////////////////////

    // Words only come back while the port strobes a read
    assign data1      = read_m1 ? mem[address1[7:0]] : 'x;
    assign read_data2 = read_m2 ? mem[address2[7:0]] : 'x;

    always @(posedge clk) begin
        if (write_m2) begin
            mem[address2[7:0]] <= write_data2;
        end
    end

    //////////////////////////////////////////////////
    // Assembly helpers
    //////////////////////////////////////////////////

    function automatic word_t encode_rtype(funct_e fn, reg_idx_t rs, reg_idx_t rt,
                                           reg_idx_t rd);
        word_t w;
        w = '0;
        w[`ISA_OPCODE] = OP_RTYPE;
        w[`ISA_RS] = rs;
        w[`ISA_RT] = rt;
        w[`ISA_RD] = rd;
        w[`ISA_FUNCT] = fn;
        return w;
    endfunction

    function automatic word_t encode_itype(opcode_e op, reg_idx_t rs, reg_idx_t rt,
                                           logic [7:0] imm);
        word_t w;
        w = '0;
        w[`ISA_OPCODE] = op;
        w[`ISA_RS] = rs;
        w[`ISA_RT] = rt;
        w[`ISA_IMM] = imm;
        return w;
    endfunction

    function automatic word_t encode_jtype(opcode_e op, word_t target);
        word_t w;
        w = '0;
        w[`ISA_OPCODE] = op;
        w[`ISA_TARGET] = target[11:0];
        return w;
    endfunction

    // Instruction on the execution path
    task automatic place(word_t w);
        mem[asm_pc[7:0]] <= w;
        asm_pc++;
        path_len++;
    endtask

    // Instruction that a taken branch or a halt must discard
    task automatic place_skipped(word_t w);
        mem[asm_pc[7:0]] <= w;
        asm_pc++;
    endtask

    task automatic expect_output(word_t value);
        row_t row;
        row.value = value;
        row.count = path_len;
        expect_rows.push_back(row);
    endtask

    // r2 = r3 op r1, then written out
    task automatic place_alu_case(funct_e fn, word_t expected);
        place(encode_rtype(fn, 2'd3, 2'd1, 2'd2));
        place(encode_rtype(FN_WWD, 2'd2, 2'd0, 2'd0));
        expect_output(expected);
    endtask

    // r1 = 0x0080 and r3 = 0xFFFD around every branch case
    task automatic place_branch_case(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic taken);
        place(encode_itype(op, rs, rt, 8'h01));
        if (taken) begin
            place_skipped(encode_rtype(FN_WWD, 2'd3, 2'd0, 2'd0));
        end else begin
            place(encode_rtype(FN_WWD, 2'd3, 2'd0, 2'd0));
            expect_output(16'hFFFD);
        end
        place(encode_rtype(FN_WWD, 2'd1, 2'd0, 2'd0));
        expect_output(16'h0080);
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    always @(negedge clk) begin
        if (i_cpu.i_cpu_checker.fail_count != 0) begin
            $display("A port assertion in cpu_checker failed");
            abort_run();
        end
    end

    // Reset cycles included in the limit
    initial begin
        wait (program_ready);
        repeat (16 + expect_rows.size() * 20 + 200) @(posedge clk);
        $display("The program did not reach its halt before the watchdog expired");
        abort_run();
    end

    initial begin
        word_t data_words [8];
        word_t sums [8];
        word_t link_pc;
        word_t target;
        word_t total;
        reset_n = 1'b1;
        for (int a = 0; a < 256; a++) begin
            mem[a] <= {8'(~a), 8'(a)};
        end
        for (int k = 0; k < 8; k++) begin
            data_words[k] = 16'($random(seed));
            mem[128 + k] <= data_words[k];
        end

        // Immediates and register functions
        place(encode_itype(OP_ADI, 2'd0, 2'd1, 8'h35));
        place(encode_rtype(FN_WWD, 2'd1, 2'd0, 2'd0));
        expect_output(16'h0035);
        place(encode_itype(OP_ADI, 2'd0, 2'd3, 8'hFD));
        place(encode_rtype(FN_WWD, 2'd3, 2'd0, 2'd0));
        expect_output(16'hFFFD);
        place(encode_itype(OP_ORI, 2'd1, 2'd1, 8'hC0));
        place(encode_rtype(FN_WWD, 2'd1, 2'd0, 2'd0));
        expect_output(alu_b);
        place(encode_itype(OP_LHI, 2'd0, 2'd3, 8'hA5));
        place(encode_itype(OP_ORI, 2'd3, 2'd3, 8'h5A));
        place(encode_rtype(FN_WWD, 2'd3, 2'd0, 2'd0));
        expect_output(alu_a);
        place_alu_case(FN_ADD, alu_a + alu_b);
        place_alu_case(FN_SUB, alu_a - alu_b);
        place_alu_case(FN_AND, alu_a & alu_b);
        place_alu_case(FN_ORR, alu_a | alu_b);
        place_alu_case(FN_NOT, ~alu_a);
        place_alu_case(FN_TCP, 16'd0 - alu_a);
        place_alu_case(FN_SHL, alu_a << 1);
        place_alu_case(FN_SHR, word_t'($signed(alu_a) >>> 1));

        // Pairwise sums stored at 136 and read back
        place(encode_itype(OP_LHI, 2'd0, 2'd1, 8'h00));
        place(encode_itype(OP_ORI, 2'd1, 2'd1, 8'h80));
        for (int k = 0; k < 8; k++) begin
            place(encode_itype(OP_LWD, 2'd1, 2'd2, 8'(k)));
            place(encode_itype(OP_LWD, 2'd1, 2'd3, 8'((k + 1) % 8)));
            place(encode_rtype(FN_ADD, 2'd2, 2'd3, 2'd2));
            place(encode_itype(OP_SWD, 2'd1, 2'd2, 8'(8 + k)));
            place(encode_itype(OP_LWD, 2'd1, 2'd3, 8'(8 + k)));
            place(encode_rtype(FN_WWD, 2'd3, 2'd0, 2'd0));
            sums[k] = data_words[k] + data_words[(k + 1) % 8];
            expect_output(sums[k]);
        end

        // Branches with r1 = r2 = 0x0080, r3 = 0xFFFD, r0 = 0
        place(encode_itype(OP_ADI, 2'd0, 2'd3, 8'hFD));
        place(encode_itype(OP_ADI, 2'd1, 2'd2, 8'h00));
        place_branch_case(OP_BNE, 2'd1, 2'd3, 1'b1);
        place_branch_case(OP_BNE, 2'd1, 2'd2, 1'b0);
        place_branch_case(OP_BEQ, 2'd1, 2'd2, 1'b1);
        place_branch_case(OP_BEQ, 2'd1, 2'd3, 1'b0);
        place_branch_case(OP_BGZ, 2'd1, 2'd0, 1'b1);
        place_branch_case(OP_BGZ, 2'd3, 2'd0, 1'b0);
        place_branch_case(OP_BLZ, 2'd3, 2'd0, 1'b1);
        place_branch_case(OP_BLZ, 2'd1, 2'd0, 1'b0);

        // Jumps that each skip one word
        place(encode_jtype(OP_JMP, asm_pc + 16'd2));
        place_skipped(encode_rtype(FN_WWD, 2'd3, 2'd0, 2'd0));
        place(encode_rtype(FN_WWD, 2'd1, 2'd0, 2'd0));
        expect_output(16'h0080);
        link_pc = asm_pc + 16'd1;
        place(encode_jtype(OP_JAL, asm_pc + 16'd2));
        place_skipped(encode_rtype(FN_WWD, 2'd3, 2'd0, 2'd0));
        place(encode_rtype(FN_WWD, 2'd2, 2'd0, 2'd0));
        expect_output(link_pc);
        target = asm_pc + 16'd3;
        place(encode_itype(OP_ADI, 2'd0, 2'd3, target[7:0]));
        place(encode_rtype(FN_JPR, 2'd3, 2'd0, 2'd0));
        place_skipped(encode_rtype(FN_WWD, 2'd1, 2'd0, 2'd0));
        place(encode_rtype(FN_WWD, 2'd3, 2'd0, 2'd0));
        expect_output(target);
        target = asm_pc + 16'd3;
        link_pc = asm_pc + 16'd2;
        place(encode_itype(OP_ADI, 2'd0, 2'd3, target[7:0]));
        place(encode_rtype(FN_JRL, 2'd3, 2'd0, 2'd0));
        place_skipped(encode_rtype(FN_WWD, 2'd3, 2'd0, 2'd0));
        place(encode_rtype(FN_WWD, 2'd2, 2'd0, 2'd0));
        expect_output(link_pc);

        place(encode_rtype(FN_HLT, 2'd0, 2'd0, 2'd0));
        total = path_len;
        place_skipped(encode_rtype(FN_WWD, 2'd1, 2'd0, 2'd0));
        program_ready = 1'b1;

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_word("num_inst", num_inst, 16'd0);
        check_word("output_port", output_port, 16'd0);
        check_word("address1", address1, 16'd0);
        check_flag("is_halted", is_halted, 1'b0);
        check_flag("read_m1", read_m1, 1'b0);
        check_flag("read_m2", read_m2, 1'b0);
        check_flag("write_m2", write_m2, 1'b0);
        @(posedge clk);
        reset_n <= 1'b0;

        for (int i = 0; i < expect_rows.size(); i++) begin
            do begin
                @(negedge clk);
            end while (num_inst < expect_rows[i].count);
            check_word("num_inst", num_inst, expect_rows[i].count);
            check_word("output_port", output_port, expect_rows[i].value);
        end

        while (!is_halted) begin
            @(negedge clk);
        end
        check_word("num_inst", num_inst, total);
        for (int k = 0; k < 8; k++) begin
            check_word($sformatf("mem[%0d]", 136 + k), mem[136 + k], sums[k]);
        end
        repeat (20) @(negedge clk);
        check_flag("is_halted", is_halted, 1'b1);
        check_word("num_inst", num_inst, total);
        check_word("output_port", output_port, expect_rows[expect_rows.size() - 1].value);

        if (i_cpu.i_cpu_checker.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("A port assertion in cpu_checker failed");
            abort_run();
        end
    end

endmodule

// ==== cpu.f ====
+incdir+include
logic/cpu_pkg.sv
logic/inst_queue.sv
logic/fetch_unit.sv
logic/register_file.sv
logic/alu.sv
logic/execute_unit.sv
logic/cpu.sv
bench/cpu_checker.sv
bench/cpu_tb.sv
